// ==== common/objram_params.svh ====
/*
  Object table geometry and CPU register map
  Table addresses sit below the control register, one bank per 2 KB half
*/
`ifndef OBJRAM_PARAMS_SVH
`define OBJRAM_PARAMS_SVH

`default_nettype none

// Entries per bank, one object each
`define OBJ_ENTRIES 256

// Entry index width, matches OBJ_ENTRIES
`define OBJ_IDX_W 8

// Byte address of the bank control register
`define OBJ_CTRL_ADDR 13'h1000

// Attr bit flagging the end of the object list
`define OBJ_END_BIT 15

`default_nettype wire

`endif

// ==== common/objram_pkg.sv ====
/*
  Shared types for the object attribute memory
  Word select order inside an entry is X, Y, code, attr
*/
`include "objram_params.svh"
`default_nettype none

package objram_pkg;

    // One 16-bit table word
    typedef logic [15:0] obj_word_t;

    // Entry index inside one bank
    typedef logic [`OBJ_IDX_W-1:0] obj_idx_t;

    // Word within an entry
    // 0 X, 1 Y, 2 code, 3 attr
    typedef logic [1:0] obj_sel_t;

    // APB byte address
    typedef logic [12:0] apb_addr_t;

    // Display scanner FSM
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        FETCH   = 3'd1,
        WAIT_RD = 3'd2,
        OFFER   = 3'd3,
        DONE    = 3'd4
    } scan_state_t;

endpackage

`default_nettype wire

// ==== common/objram_if.sv ====
/*
  CPU side and display side buses of the object banks
  Read data on both buses is valid one cycle after the request
*/
`timescale 1ns/1ps
`default_nettype none

// CPU port, APB decoder to banks
interface obj_wr_if;
    logic                  bank;
    objram_pkg::obj_idx_t  idx;
    objram_pkg::obj_sel_t  sel;
    logic [1:0]            be;
    objram_pkg::obj_word_t wdata;
    logic                  we;
    logic                  re;
    objram_pkg::obj_word_t rdata;

    modport master (output bank, idx, sel, be, wdata, we, re, input rdata);
    modport slave  (input bank, idx, sel, be, wdata, we, re, output rdata);
endinterface

// Display port, scanner to banks
interface obj_rd_if;
    logic                  req;
    objram_pkg::obj_idx_t  idx;
    objram_pkg::obj_word_t x;
    objram_pkg::obj_word_t y;
    objram_pkg::obj_word_t code;
    objram_pkg::obj_word_t attr;

    modport master (output req, idx, input x, y, code, attr);
    modport slave  (input req, idx, output x, y, code, attr);
endinterface

`default_nettype wire

// ==== rtl/objram_apb.sv ====
/*
  APB slave for the object table and its bank control register
  Every transfer has exactly one wait state, no other back-pressure
  Unmapped addresses answer with pslverr, read data 0, no side effect
*/
`include "objram_params.svh"
`timescale 1ns/1ps
`default_nettype none

module objram_apb (
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  objram_pkg::apb_addr_t paddr,
    input  objram_pkg::obj_word_t pwdata,
    input  logic [1:0]            pstrb,
    output objram_pkg::obj_word_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  obank,
    obj_wr_if.master              wr
);

    // First access cycle, the one with pready still low
    logic acc1;
    // Address decode
    logic tbl_hit;
    logic ctrl_hit;
    logic bad_addr;
    // Read source for the completing cycle
    logic rd_tbl_q;
    logic rd_ctrl_q;

    assign acc1     = psel & penable & ~pready;
    // Lower 4 KB is the table, both banks
    assign tbl_hit  = ~paddr[12];
    assign ctrl_hit = (paddr == `OBJ_CTRL_ADDR);
    assign bad_addr = ~tbl_hit & ~ctrl_hit;

    // Bank XOR keeps the CPU bank at the low half
    assign wr.bank  = paddr[11] ^ obank;
    assign wr.idx   = paddr[10:3];
    assign wr.sel   = paddr[2:1];
    // Strobes are active high, same as byte enables
    assign wr.be    = pstrb;
    assign wr.wdata = pwdata;
    // Write lands at the end of the first access cycle
    assign wr.we    = acc1 & pwrite & tbl_hit;
    // Read data comes back in the second access cycle
    assign wr.re    = acc1 & ~pwrite & tbl_hit;

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            pready    <= 1'b0;
            pslverr   <= 1'b0;
            rd_tbl_q  <= 1'b0;
            rd_ctrl_q <= 1'b0;
            obank     <= 1'b0;
        end else begin
            // Single wait state, pready lasts one cycle
            pready    <= acc1;
            pslverr   <= acc1 & bad_addr;
            rd_tbl_q  <= acc1 & ~pwrite & tbl_hit;
            rd_ctrl_q <= acc1 & ~pwrite & ctrl_hit;
            // Bank bit lives in the low byte lane
            if (acc1 && pwrite && ctrl_hit && pstrb[0]) begin
                obank <= pwdata[0];
            end
        end
    end

    // Read mux, zero for writes and for error reads
    always_comb begin
        if (rd_tbl_q) begin
            prdata = wr.rdata;
        end else if (rd_ctrl_q) begin
            prdata = {15'd0, obank};
        end else begin
            prdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== objram/objram_banks.sv ====
/*
  Two banks of object entries, four 16-bit lanes per entry
  CPU port writes byte lanes and reads back one word
  Display port reads a whole entry from the bank not selected by obank
*/
`include "objram_params.svh"
`timescale 1ns/1ps
`default_nettype none

module objram_banks (
    input  logic     clk_cpu,
    input  logic     obank,
    obj_wr_if.slave  wr,
    obj_rd_if.slave  rd
);

    localparam int DEPTH = 2 * `OBJ_ENTRIES;
    localparam int AW    = `OBJ_IDX_W + 1;

    // Physical addresses, bank bit on top
    logic [AW-1:0] cpu_addr;
    logic [AW-1:0] disp_addr;

    // Lane outputs, index is the word select
    objram_pkg::obj_word_t cpu_word  [0:3];
    objram_pkg::obj_word_t disp_word [0:3];

    // Word select of the pending CPU read
    objram_pkg::obj_sel_t sel_q;

    assign cpu_addr  = {wr.bank, wr.idx};
    // Display side always shows the other bank
    assign disp_addr = {~obank, rd.idx};

    // One RAM per word of the entry
    // X and code feed one half of the engine, Y and attr the other
    for (genvar l = 0; l < 4; l++) begin : g_lane
        objram_pkg::obj_word_t mem [0:DEPTH-1];
        objram_pkg::obj_word_t cpu_q;
        objram_pkg::obj_word_t disp_q;
        logic                  lane_we;

        assign lane_we = wr.we && (wr.sel == objram_pkg::obj_sel_t'(l));

        always_ff @(posedge clk_cpu) begin
            // Byte lanes written apart
            if (lane_we && wr.be[0]) begin
                mem[cpu_addr][7:0] <= wr.wdata[7:0];
            end
            if (lane_we && wr.be[1]) begin
                mem[cpu_addr][15:8] <= wr.wdata[15:8];
            end
            // CPU readback
            if (wr.re) begin
                cpu_q <= mem[cpu_addr];
            end
            // Display fetch
            if (rd.req) begin
                disp_q <= mem[disp_addr];
            end
        end

        assign cpu_word[l]  = cpu_q;
        assign disp_word[l] = disp_q;
    end

    // Remember which word the CPU asked for
    always_ff @(posedge clk_cpu) begin
        if (wr.re) begin
            sel_q <= wr.sel;
        end
    end

    assign wr.rdata = cpu_word[sel_q];

    // Whole entry toward the scanner
    assign rd.x    = disp_word[0];
    assign rd.y    = disp_word[1];
    assign rd.code = disp_word[2];
    assign rd.attr = disp_word[3];

endmodule

`default_nettype wire

// ==== rtl/obj_scanner.sv ====
/*
  Walks the display bank from entry 0 and offers each object
  Stops before an entry with the end bit set, or after the last entry
  A bank toggle during a scan is not guarded, toggle between scans
*/
`include "objram_params.svh"
`timescale 1ns/1ps
`default_nettype none

module obj_scanner (
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    input  logic                  frame_start,
    input  logic                  obj_ready,
    output logic                  obj_valid,
    output logic                  scan_busy,
    output objram_pkg::obj_word_t obj_x,
    output objram_pkg::obj_word_t obj_y,
    output objram_pkg::obj_word_t obj_code,
    output objram_pkg::obj_word_t obj_attr,
    obj_rd_if.master              rd
);

    objram_pkg::scan_state_t state;
    // Entry being fetched or offered
    objram_pkg::obj_idx_t    idx;
    logic                    last_idx;
    logic                    end_mark;

    assign last_idx = (idx == objram_pkg::obj_idx_t'(`OBJ_ENTRIES - 1));
    // Only meaningful in WAIT_RD, when bank data is fresh
    assign end_mark = rd.attr[`OBJ_END_BIT];

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            state <= objram_pkg::IDLE;
            idx   <= '0;
        end else begin
            case (state)
                objram_pkg::IDLE: begin
                    // frame_start only counts when idle
                    if (frame_start) begin
                        idx   <= '0;
                        state <= objram_pkg::FETCH;
                    end
                end
                objram_pkg::FETCH: begin
                    state <= objram_pkg::WAIT_RD;
                end
                objram_pkg::WAIT_RD: begin
                    // End entry itself is never offered
                    if (end_mark) begin
                        state <= objram_pkg::DONE;
                    end else begin
                        state <= objram_pkg::OFFER;
                    end
                end
                objram_pkg::OFFER: begin
                    // Hold here under back-pressure, no fetch ahead
                    if (obj_ready) begin
                        if (last_idx) begin
                            state <= objram_pkg::DONE;
                        end else begin
                            idx   <= idx + objram_pkg::obj_idx_t'(1);
                            state <= objram_pkg::FETCH;
                        end
                    end
                end
                objram_pkg::DONE: begin
                    state <= objram_pkg::IDLE;
                end
                default: begin
                    state <= objram_pkg::IDLE;
                end
            endcase
        end
    end

    // Capture the entry once, keeps the offer stable
    always_ff @(posedge clk_cpu) begin
        if (state == objram_pkg::WAIT_RD) begin
            obj_x    <= rd.x;
            obj_y    <= rd.y;
            obj_code <= rd.code;
            obj_attr <= rd.attr;
        end
    end

    // One bank read per entry
    assign rd.req = (state == objram_pkg::FETCH);
    assign rd.idx = idx;

    assign obj_valid = (state == objram_pkg::OFFER);
    assign scan_busy = (state != objram_pkg::IDLE);

endmodule

`default_nettype wire

// ==== rtl/objram_sys.sv ====
/*
  Object attribute memory, APB on the CPU side, valid/ready to the engine
  Single clock, the display bank is the one the CPU does not write
*/
`timescale 1ns/1ps
`default_nettype none

module objram_sys (
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    // APB
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  objram_pkg::apb_addr_t paddr,
    input  objram_pkg::obj_word_t pwdata,
    input  logic [1:0]            pstrb,
    output objram_pkg::obj_word_t prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Video side
    input  logic                  frame_start,
    input  logic                  obj_ready,
    output logic                  obj_valid,
    output objram_pkg::obj_word_t obj_x,
    output objram_pkg::obj_word_t obj_y,
    output objram_pkg::obj_word_t obj_code,
    output objram_pkg::obj_word_t obj_attr,
    output logic                  scan_busy
);

    // CPU bank bit
    logic obank;

    obj_wr_if wr_bus ();
    obj_rd_if rd_bus ();

    objram_apb u_apb (
        .clk_cpu (clk_cpu),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .obank   (obank),
        .wr      (wr_bus.master)
    );

    objram_banks u_banks (
        .clk_cpu (clk_cpu),
        .obank   (obank),
        .wr      (wr_bus.slave),
        .rd      (rd_bus.slave)
    );

    obj_scanner u_scan (
        .clk_cpu     (clk_cpu),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .obj_ready   (obj_ready),
        .obj_valid   (obj_valid),
        .scan_busy   (scan_busy),
        .obj_x       (obj_x),
        .obj_y       (obj_y),
        .obj_code    (obj_code),
        .obj_attr    (obj_attr),
        .rd          (rd_bus.master)
    );

endmodule

`default_nettype wire

// ==== sim/objram_clkgen.sv ====
/*
  Testbench clock and reset, 40 ns period
  rst_n low over the first two rising edges, released on a falling edge
*/
`timescale 1ns/1ps
`default_nettype none

module objram_clkgen (
    output logic clk_cpu,
    output logic rst_n
);

    localparam int HALF_NS = 20;

    initial begin
        clk_cpu = 1'b0;
        forever #HALF_NS clk_cpu = ~clk_cpu;
    end

    // Two rising edges in reset
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk_cpu);
        @(negedge clk_cpu);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/objram_monitor.sv ====
/*
  Watches APB and the object stream, keeps its own copy of both banks
  Model is built only from completed APB writes, uninitialized words stay X
  A scan is expected to stop before the first end-marked entry of the display bank
*/
`include "objram_params.svh"
`timescale 1ns/1ps
`default_nettype none

module objram_monitor (
    input  logic                  clk_cpu,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  objram_pkg::apb_addr_t paddr,
    input  objram_pkg::obj_word_t pwdata,
    input  logic [1:0]            pstrb,
    input  objram_pkg::obj_word_t prdata,
    input  logic                  pready,
    input  logic                  pslverr,
    input  logic                  frame_start,
    input  logic                  obj_ready,
    input  logic                  obj_valid,
    input  logic                  scan_busy,
    input  objram_pkg::obj_word_t obj_x,
    input  objram_pkg::obj_word_t obj_y,
    input  objram_pkg::obj_word_t obj_code,
    input  objram_pkg::obj_word_t obj_attr,
    // Table expectations for the current step
    input  logic                  exp_en,
    input  objram_pkg::obj_word_t exp_data,
    input  logic                  exp_err,
    output int                    err_cnt,
    output int                    xfer_cnt,
    output int                    rec_cnt
);

    // Physical bank, entry, word
    objram_pkg::obj_word_t model [0:1][0:`OBJ_ENTRIES-1][0:3];
    logic m_bank = 1'b0;
    logic after_rst = 1'b0;
    logic start_q = 1'b0;
    logic busy_q = 1'b0;
    int   scan_idx = 0;
    int   errs = 0;
    int   xfers = 0;
    int   recs = 0;

    assign err_cnt  = errs;
    assign xfer_cnt = xfers;
    assign rec_cnt  = recs;

    // Anything above the control register is unmapped
    function automatic logic bad_addr(input objram_pkg::apb_addr_t a);
        return a > `OBJ_CTRL_ADDR;
    endfunction

    // Records a scan of bank b should emit
    function automatic int end_count(input logic b);
        for (int i = 0; i < `OBJ_ENTRIES; i++) begin
            if (model[b][i][3][`OBJ_END_BIT] === 1'b1) begin
                return i;
            end
        end
        return `OBJ_ENTRIES;
    endfunction

    task automatic mismatch(input string name, input logic [15:0] want, input logic [15:0] got);
        $display("Error: time %0t signal %s expected %h actual %h", $time, name, want, got);
        errs++;
    endtask

    always @(posedge clk_cpu) begin
        objram_pkg::obj_word_t want;
        logic                  pb;
        if (!rst_n) begin
            m_bank    = 1'b0;
            after_rst = 1'b1;
            start_q   = 1'b0;
            busy_q    = 1'b0;
        end else begin
            // First edge out of reset sees the reset values
            if (after_rst && (pready || pslverr || obj_valid || scan_busy)) begin
                $display("Error: time %0t control outputs not all low after reset", $time);
                errs++;
            end
            after_rst = 1'b0;

            // APB completion cycle
            if (psel && penable && pready) begin
                xfers++;
                pb = paddr[11] ^ m_bank;
                if (pslverr !== bad_addr(paddr)) begin
                    mismatch("pslverr", 16'(bad_addr(paddr)), 16'(pslverr));
                end
                if (exp_en && pslverr !== exp_err) begin
                    mismatch("pslverr", 16'(exp_err), 16'(pslverr));
                end
                if (!pwrite) begin
                    if (bad_addr(paddr)) begin
                        want = '0;
                    end else if (paddr == `OBJ_CTRL_ADDR) begin
                        want = {15'd0, m_bank};
                    end else begin
                        want = model[pb][paddr[10:3]][paddr[2:1]];
                    end
                    if (prdata !== want) mismatch("prdata", want, prdata);
                    if (exp_en && prdata !== exp_data) mismatch("prdata", exp_data, prdata);
                end else if (paddr == `OBJ_CTRL_ADDR) begin
                    if (pstrb[0]) m_bank = pwdata[0];
                end else if (!bad_addr(paddr)) begin
                    if (pstrb[0]) model[pb][paddr[10:3]][paddr[2:1]][7:0] = pwdata[7:0];
                    if (pstrb[1]) model[pb][paddr[10:3]][paddr[2:1]][15:8] = pwdata[15:8];
                end
            end

            // Accepted frame_start must raise scan_busy
            if (start_q && !scan_busy) begin
                $display("Error: time %0t scan did not start after frame_start", $time);
                errs++;
            end
            start_q = frame_start && !scan_busy;
            if (start_q) scan_idx = 0;

            // Display bank is the one opposite the bank bit
            if (obj_valid && obj_ready) begin
                pb = ~m_bank;
                if (scan_idx >= `OBJ_ENTRIES) begin
                    $display("Error: time %0t record emitted past the last entry", $time);
                    errs++;
                end else begin
                    if (obj_x !== model[pb][scan_idx][0]) begin
                        mismatch("obj_x", model[pb][scan_idx][0], obj_x);
                    end
                    if (obj_y !== model[pb][scan_idx][1]) begin
                        mismatch("obj_y", model[pb][scan_idx][1], obj_y);
                    end
                    if (obj_code !== model[pb][scan_idx][2]) begin
                        mismatch("obj_code", model[pb][scan_idx][2], obj_code);
                    end
                    if (obj_attr !== model[pb][scan_idx][3]) begin
                        mismatch("obj_attr", model[pb][scan_idx][3], obj_attr);
                    end
                end
                scan_idx++;
                recs++;
            end

            // Scan end, record count against the end marker
            if (busy_q && !scan_busy && scan_idx != end_count(~m_bank)) begin
                $display("Error: time %0t scan ended after %0d records, expected %0d",
                         $time, scan_idx, end_count(~m_bank));
                errs++;
            end
            busy_q = scan_busy;
        end
    end

endmodule

`default_nettype wire

// ==== sim/objram_chk.sv ====
/*
  Protocol assertions, bound into objram_sys
  Failures raise $error and bump fail_cnt, read by the testbench at the end
*/
`timescale 1ns/1ps
`default_nettype none

module objram_chk (
    input logic        clk_cpu,
    input logic        rst_n,
    input logic        psel,
    input logic        penable,
    input logic        pready,
    input logic        obj_valid,
    input logic        obj_ready,
    input logic        scan_busy,
    input logic [15:0] obj_x,
    input logic [15:0] obj_y,
    input logic [15:0] obj_code,
    input logic [15:0] obj_attr
);

    int fail_cnt = 0;

    // No pready straight after setup
    a_setup: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        psel && !penable |=> !pready)
        else begin
            $error("pready high right after the setup phase");
            fail_cnt++;
        end

    // First access cycle is the wait state, second completes
    a_done: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        psel && penable && !pready |=> pready)
        else begin
            $error("pready missing on the second access cycle");
            fail_cnt++;
        end

    a_pulse: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        pready |=> !pready)
        else begin
            $error("pready held longer than one cycle");
            fail_cnt++;
        end

    // Offer held with its data until taken
    a_hold: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        obj_valid && !obj_ready |=>
            obj_valid && $stable({obj_x, obj_y, obj_code, obj_attr}))
        else begin
            $error("obj_valid or object data changed before obj_ready");
            fail_cnt++;
        end

    a_busy: assert property (@(posedge clk_cpu) disable iff (!rst_n)
        obj_valid |-> scan_busy)
        else begin
            $error("obj_valid high while scan_busy is low");
            fail_cnt++;
        end

endmodule

bind objram_sys objram_chk u_chk (
    .clk_cpu   (clk_cpu),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .obj_valid (obj_valid),
    .obj_ready (obj_ready),
    .scan_busy (scan_busy),
    .obj_x     (obj_x),
    .obj_y     (obj_y),
    .obj_code  (obj_code),
    .obj_attr  (obj_attr)
);

`default_nettype wire

// ==== sim/objram_tb.sv ====
/*
  Testbench top, steps of a table run in order
  APB and frame_start change on the falling edge, obj_ready is random (seed 32'h92f4)
  A cycle limit worked out from the table ends a hung run
*/
`include "objram_params.svh"
`timescale 1ns/1ps
`default_nettype none

module objram_tb;

    typedef enum logic [1:0] {ST_WR, ST_RD, ST_FILL, ST_SCAN} step_kind_t;

    // RD data is the expected read value
    // FILL data is the end entry index, 256 for none
    typedef struct packed {
        step_kind_t            kind;
        objram_pkg::apb_addr_t addr;
        objram_pkg::obj_word_t data;
        logic [1:0]            strb;
        logic                  err;
    } step_t;

    localparam int NSTEP = 22;

    logic clk_cpu;
    logic rst_n;
    logic psel;
    logic penable;
    logic pwrite;
    objram_pkg::apb_addr_t paddr;
    objram_pkg::obj_word_t pwdata;
    logic [1:0] pstrb;
    objram_pkg::obj_word_t prdata;
    logic pready;
    logic pslverr;
    logic frame_start;
    logic obj_ready = 1'b0;
    logic obj_valid;
    logic scan_busy;
    objram_pkg::obj_word_t obj_x;
    objram_pkg::obj_word_t obj_y;
    objram_pkg::obj_word_t obj_code;
    objram_pkg::obj_word_t obj_attr;
    logic exp_en;
    logic exp_err;
    objram_pkg::obj_word_t exp_data;
    int err_cnt;
    int xfer_cnt;
    int rec_cnt;
    int cycles = 0;
    int limit = 0;
    step_t steps [NSTEP];

    objram_clkgen u_clk (.clk_cpu(clk_cpu), .rst_n(rst_n));

    objram_sys u_dut (
        .clk_cpu(clk_cpu), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .frame_start(frame_start), .obj_ready(obj_ready),
        .obj_valid(obj_valid), .obj_x(obj_x), .obj_y(obj_y), .obj_code(obj_code),
        .obj_attr(obj_attr), .scan_busy(scan_busy)
    );

    objram_monitor u_mon (
        .clk_cpu(clk_cpu), .rst_n(rst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .frame_start(frame_start), .obj_ready(obj_ready),
        .obj_valid(obj_valid), .scan_busy(scan_busy), .obj_x(obj_x), .obj_y(obj_y),
        .obj_code(obj_code), .obj_attr(obj_attr), .exp_en(exp_en),
        .exp_data(exp_data), .exp_err(exp_err), .err_cnt(err_cnt),
        .xfer_cnt(xfer_cnt), .rec_cnt(rec_cnt)
    );

    // Fill data, every address bit counts
    function automatic objram_pkg::obj_word_t fill_word(input objram_pkg::apb_addr_t a);
        return {a[4:0], a[12:2]} ^ {a[7:0], a[12:5]} ^ 16'h6c1b;
    endfunction

    // Setup, wait state, completion, then idle
    task automatic apb_transfer(input logic w, input objram_pkg::apb_addr_t a,
                                input objram_pkg::obj_word_t d, input logic [1:0] s);
        @(negedge clk_cpu);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = w;
        paddr   = a;
        pwdata  = d;
        pstrb   = s;
        @(negedge clk_cpu);
        penable = 1'b1;
        @(negedge clk_cpu);
        while (!pready) @(negedge clk_cpu);
        @(negedge clk_cpu);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Whole CPU-visible half at base, attr bit 15 only on end_idx
    task automatic fill_bank(input objram_pkg::apb_addr_t base, input int end_idx);
        objram_pkg::apb_addr_t a;
        objram_pkg::obj_word_t d;
        for (int i = 0; i < `OBJ_ENTRIES; i++) begin
            for (int w = 0; w < 4; w++) begin
                a = base | 13'(i << 3) | 13'(w << 1);
                d = fill_word(a);
                if (w == 3) d[`OBJ_END_BIT] = (i == end_idx);
                apb_transfer(1'b1, a, d, 2'b11);
            end
        end
    endtask

    task automatic pulse_frame();
        @(negedge clk_cpu);
        frame_start = 1'b1;
        @(negedge clk_cpu);
        frame_start = 1'b0;
    endtask

    // Second pulse lands mid-scan and must be ignored
    task automatic run_scan();
        pulse_frame();
        repeat (6) @(negedge clk_cpu);
        pulse_frame();
        while (scan_busy) @(negedge clk_cpu);
    endtask

    // Random back-pressure, ready three times in four
    always @(negedge clk_cpu) begin
        obj_ready <= ($urandom % 4) != 0;
    end

    always @(posedge clk_cpu) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        int seed;
        seed        = $urandom(32'h92f4);
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pstrb       = 2'b00;
        frame_start = 1'b0;
        exp_en      = 1'b0;
        exp_err     = 1'b0;
        exp_data    = '0;
        steps = '{
            '{ST_WR,   13'h0010, 16'h1234, 2'b11, 1'b0},
            '{ST_WR,   13'h0010, 16'habcd, 2'b01, 1'b0},
            '{ST_RD,   13'h0010, 16'h12cd, 2'b11, 1'b0},
            '{ST_WR,   13'h0010, 16'h5600, 2'b10, 1'b0},
            '{ST_RD,   13'h0010, 16'h56cd, 2'b11, 1'b0},
            '{ST_WR,   13'h0020, 16'h1111, 2'b11, 1'b0},
            '{ST_WR,   13'h0820, 16'h2222, 2'b11, 1'b0},
            '{ST_WR,   13'h1000, 16'h0001, 2'b01, 1'b0},
            '{ST_RD,   13'h1000, 16'h0001, 2'b11, 1'b0},
            '{ST_RD,   13'h0020, 16'h2222, 2'b11, 1'b0},
            '{ST_RD,   13'h0820, 16'h1111, 2'b11, 1'b0},
            '{ST_WR,   13'h1000, 16'h0000, 2'b01, 1'b0},
            '{ST_RD,   13'h0020, 16'h1111, 2'b11, 1'b0},
            '{ST_WR,   13'h1010, 16'hffff, 2'b11, 1'b1},
            '{ST_RD,   13'h1800, 16'h0000, 2'b11, 1'b1},
            '{ST_RD,   13'h0010, 16'h56cd, 2'b11, 1'b0},
            '{ST_FILL, 13'h0000, 16'd5,    2'b11, 1'b0},
            '{ST_FILL, 13'h0800, 16'd256,  2'b11, 1'b0},
            '{ST_SCAN, 13'h0000, 16'h0000, 2'b00, 1'b0},
            '{ST_WR,   13'h1000, 16'h0001, 2'b01, 1'b0},
            '{ST_SCAN, 13'h0000, 16'h0000, 2'b00, 1'b0},
            '{ST_RD,   13'h1000, 16'h0001, 2'b11, 1'b0}
        };

        // 40 per step, 4 per entry scanned, 16 per entry filled
        limit = 100;
        foreach (steps[i]) begin
            limit += 40;
            if (steps[i].kind == ST_SCAN) limit += 4 * `OBJ_ENTRIES;
            if (steps[i].kind == ST_FILL) limit += 16 * `OBJ_ENTRIES;
        end

        @(posedge rst_n);
        foreach (steps[i]) begin
            exp_en   = (steps[i].kind == ST_WR) || (steps[i].kind == ST_RD);
            exp_data = steps[i].data;
            exp_err  = steps[i].err;
            case (steps[i].kind)
                ST_WR:   apb_transfer(1'b1, steps[i].addr, steps[i].data, steps[i].strb);
                ST_RD:   apb_transfer(1'b0, steps[i].addr, '0, steps[i].strb);
                ST_FILL: fill_bank(steps[i].addr, int'(steps[i].data));
                default: run_scan();
            endcase
        end
        repeat (4) @(negedge clk_cpu);

        $display("Summary: %0d transfers, %0d records, %0d mismatches, %0d assertion failures",
                 xfer_cnt, rec_cnt, err_cnt, u_dut.u_chk.fail_cnt);
        if (err_cnt == 0 && u_dut.u_chk.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== objram_sys.f ====
+incdir+common
common/objram_pkg.sv
common/objram_if.sv
rtl/objram_apb.sv
objram/objram_banks.sv
rtl/obj_scanner.sv
rtl/objram_sys.sv
sim/objram_clkgen.sv
sim/objram_monitor.sv
sim/objram_chk.sv
sim/objram_tb.sv

// ==== Bender.yml ====
package:
  name: objram_sys

sources:
  - include_dirs:
      - common
    files:
      - common/objram_pkg.sv
      - common/objram_if.sv
      - rtl/objram_apb.sv
      - objram/objram_banks.sv
      - rtl/obj_scanner.sv
      - rtl/objram_sys.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/objram_clkgen.sv
      - sim/objram_monitor.sv
      - sim/objram_chk.sv
      - sim/objram_tb.sv
